//--- logic/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // 2K byte array, upper three address bits go out as block bits
    localparam int mem_addr_w = 11;
    localparam int data_w     = 8;

    localparam logic [3:0] device_code = 4'b1010;  // upper nibble of control byte

    // operations understood by the bit engine
    typedef enum logic [1:0] {
        op_start = 2'b00,  // repeated start when bus not idle
        op_stop  = 2'b01,
        op_write = 2'b10,  // eight bits out then slave ack
        op_read  = 2'b11   // eight bits in then master ack
    } bus_op_e;

endpackage

`default_nettype wire

//--- logic/serial_bit_engine.sv
`default_nettype none

module serial_bit_engine import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4
) (
    input  wire                CLK,
    input  wire                RESET,
    input  wire                op_valid,
    input  var  bus_op_e       op_code,
    input  wire [data_w-1:0]   op_byte,
    input  wire                op_ack_bit,
    output logic               op_done,
    output logic [data_w-1:0]  rx_byte,
    output logic               rx_ack,
    output logic               scl,
    output logic               sda_oe,
    input  wire                sda_in
);

    localparam int ph_w = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;
    localparam logic [ph_w-1:0] ph_mid  = ph_w'(CLK_DIV / 2);
    localparam logic [ph_w-1:0] ph_last = ph_w'(CLK_DIV - 1);

    if (CLK_DIV < 2)
    begin : g_bad_div
        $error("serial_bit_engine needs CLK_DIV of at least 2");
    end

    logic              active;
    bus_op_e           cur_op;
    logic [ph_w-1:0]   phase;     // CLK count inside one SCL half period
    logic [4:0]        half;      // half period index within the operation
    logic [data_w-1:0] shreg;
    logic              ack_bit;

    logic       high_half;
    logic [3:0] bit_idx;
    logic       edge_op;
    logic [4:0] last_half;

    assign high_half = half[0];   // even halves low, odd halves high
    assign bit_idx   = half[4:1];
    assign edge_op   = (cur_op == op_start) || (cur_op == op_stop);
    assign last_half = edge_op ? 5'd1 : 5'd17;
    assign rx_byte   = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active  <= 1'b0;
            cur_op  <= op_start;
            phase   <= '0;
            half    <= '0;
            scl     <= 1'b1;
            sda_oe  <= 1'b0;
            op_done <= 1'b0;
            rx_ack  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;

            if (!active)
            begin
                if (op_valid)
                begin
                    active  <= 1'b1;
                    cur_op  <= op_code;
                    shreg   <= op_byte;
                    ack_bit <= op_ack_bit;
                    phase   <= '0;
                    half    <= '0;
                    rx_ack  <= 1'b0;
                end
            end
            else
            begin
                if (phase == '0)
                    scl <= high_half;

                // sda moves mid half period, away from the scl edges
                if (phase == ph_mid)
                begin
                    if (edge_op)
                    begin
                        // start pulls sda while scl high, stop releases it
                        if (high_half)
                            sda_oe <= (cur_op == op_start);
                        else
                            sda_oe <= (cur_op == op_stop);
                    end
                    else if (!high_half)
                    begin
                        if (bit_idx == 4'd8)
                            sda_oe <= (cur_op == op_read) ? !ack_bit : 1'b0;
                        else if (cur_op == op_write)
                        begin
                            sda_oe <= !shreg[data_w-1];   // msb first
                            shreg  <= {shreg[data_w-2:0], 1'b0};
                        end
                        else
                            sda_oe <= 1'b0;               // slave drives data
                    end
                end

                // sample late in the high half
                if (phase == ph_last && high_half && !edge_op)
                begin
                    if (bit_idx == 4'd8)
                    begin
                        if (cur_op == op_write)
                            rx_ack <= sda_in;   // high means refused
                    end
                    else if (cur_op == op_read)
                        shreg <= {shreg[data_w-2:0], sda_in};
                end

                if (phase == ph_last)
                begin
                    phase <= '0;
                    if (half == last_half)
                    begin
                        active  <= 1'b0;
                        op_done <= 1'b1;
                    end
                    else
                        half <= half + 5'd1;
                end
                else
                    phase <= phase + 1'b1;
            end
        end
    end

    // data only moves under scl low, start and stop are the exceptions
    a_sda_stable_high: assert property (
        @(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && $changed(sda_oe))
            |-> ($past(active) && ($past(cur_op) inside {op_start, op_stop}))
    ) else $error("sda changed while scl high outside start or stop");

endmodule

`default_nettype wire

//--- logic/eeprom_access_ctrl.sv
`default_nettype none

module eeprom_access_ctrl import eeprom_pkg::*; (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   wr,
    input  wire                   rd,
    input  wire [mem_addr_w-1:0]  addr,
    input  wire [data_w-1:0]      wr_data,
    output logic [data_w-1:0]     rd_data,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic                  op_valid,
    output bus_op_e               op_code,
    output logic [data_w-1:0]     op_byte,
    output logic                  op_ack_bit,
    input  wire                   op_done,
    input  wire [data_w-1:0]      rx_byte,
    input  wire                   rx_ack
);

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_wr,
        st_addr,
        st_data_wr,
        st_restart,
        st_ctrl_rd,
        st_data_rd,
        st_stop,
        st_finish
    } ctrl_state_e;

    ctrl_state_e           state;
    logic [mem_addr_w-1:0] addr_q;
    logic [data_w-1:0]     data_q;
    logic                  is_read;
    logic                  op_pending;   // engine busy with our last op

    logic [data_w-1:0] ctrl_wr_byte;
    logic [data_w-1:0] ctrl_rd_byte;

    // device code, block bits, direction
    assign ctrl_wr_byte = {device_code, addr_q[mem_addr_w-1:data_w], 1'b0};
    assign ctrl_rd_byte = {device_code, addr_q[mem_addr_w-1:data_w], 1'b1};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= st_idle;
            busy       <= 1'b0;
            done       <= 1'b0;
            nack       <= 1'b0;
            op_valid   <= 1'b0;
            op_pending <= 1'b0;
        end
        else
        begin
            done     <= 1'b0;
            op_valid <= 1'b0;

            if (op_valid)
                op_pending <= 1'b1;
            else if (op_done)
                op_pending <= 1'b0;

            case (state)
                st_idle:
                    if (wr || rd)
                    begin
                        addr_q   <= addr;
                        data_q   <= wr_data;
                        is_read  <= !wr;          // write wins
                        busy     <= 1'b1;
                        nack     <= 1'b0;
                        op_valid <= 1'b1;
                        op_code  <= op_start;
                        state    <= st_start;
                    end
                st_start:
                    if (op_done)
                    begin
                        op_valid <= 1'b1;
                        op_code  <= op_write;
                        op_byte  <= ctrl_wr_byte;
                        state    <= st_ctrl_wr;
                    end
                st_ctrl_wr:
                    if (op_done)
                    begin
                        op_valid <= 1'b1;
                        if (rx_ack)
                        begin
                            nack    <= 1'b1;      // no device answered
                            op_code <= op_stop;
                            state   <= st_stop;
                        end
                        else
                        begin
                            op_code <= op_write;
                            op_byte <= addr_q[data_w-1:0];
                            state   <= st_addr;
                        end
                    end
                st_addr:
                    if (op_done)
                    begin
                        op_valid <= 1'b1;
                        if (rx_ack)
                        begin
                            nack    <= 1'b1;
                            op_code <= op_stop;
                            state   <= st_stop;
                        end
                        else if (is_read)
                        begin
                            op_code <= op_start;  // random read turns the bus around
                            state   <= st_restart;
                        end
                        else
                        begin
                            op_code <= op_write;
                            op_byte <= data_q;
                            state   <= st_data_wr;
                        end
                    end
                st_data_wr:
                    if (op_done)
                    begin
                        nack     <= rx_ack;
                        op_valid <= 1'b1;
                        op_code  <= op_stop;
                        state    <= st_stop;
                    end
                st_restart:
                    if (op_done)
                    begin
                        op_valid <= 1'b1;
                        op_code  <= op_write;
                        op_byte  <= ctrl_rd_byte;
                        state    <= st_ctrl_rd;
                    end
                st_ctrl_rd:
                    if (op_done)
                    begin
                        op_valid <= 1'b1;
                        if (rx_ack)
                        begin
                            nack    <= 1'b1;
                            op_code <= op_stop;
                            state   <= st_stop;
                        end
                        else
                        begin
                            op_code    <= op_read;
                            op_ack_bit <= 1'b1;   // single byte, master nacks
                            state      <= st_data_rd;
                        end
                    end
                st_data_rd:
                    if (op_done)
                    begin
                        rd_data  <= rx_byte;
                        op_valid <= 1'b1;
                        op_code  <= op_stop;
                        state    <= st_stop;
                    end
                st_stop:
                    if (op_done)
                        state <= st_finish;
                st_finish:
                begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= st_idle;
                end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // one engine operation in flight at a time
    a_one_op: assert property (
        @(posedge CLK) disable iff (RESET)
        op_valid |-> !op_pending
    ) else $error("op_valid raised before op_done of previous operation");

endmodule

`default_nettype wire

//--- logic/eeprom_master_top.sv
`default_nettype none

module eeprom_master_top import eeprom_pkg::*; #(
    parameter int CLK_DIV = 4     // CLK cycles per SCL half period
) (
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   wr,
    input  wire                   rd,
    input  wire [mem_addr_w-1:0]  addr,
    input  wire [data_w-1:0]      wr_data,
    output logic [data_w-1:0]     rd_data,
    output logic                  busy,
    output logic                  done,
    output logic                  nack,
    output logic                  scl,
    output logic                  sda_oe,
    input  wire                   sda_in
);

    logic              op_valid;
    bus_op_e           op_code;
    logic [data_w-1:0] op_byte;
    logic              op_ack_bit;
    logic              op_done;
    logic [data_w-1:0] rx_byte;
    logic              rx_ack;

    eeprom_access_ctrl u_ctrl (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wr_data    (wr_data),
        .rd_data    (rd_data),
        .busy       (busy),
        .done       (done),
        .nack       (nack),
        .op_valid   (op_valid),
        .op_code    (op_code),
        .op_byte    (op_byte),
        .op_ack_bit (op_ack_bit),
        .op_done    (op_done),
        .rx_byte    (rx_byte),
        .rx_ack     (rx_ack)
    );

    serial_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .CLK        (CLK),
        .RESET      (RESET),
        .op_valid   (op_valid),
        .op_code    (op_code),
        .op_byte    (op_byte),
        .op_ack_bit (op_ack_bit),
        .op_done    (op_done),
        .rx_byte    (rx_byte),
        .rx_ack     (rx_ack),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .sda_in     (sda_in)
    );

endmodule

`default_nettype wire

//--- tests/eeprom_slave_model.sv
`default_nettype none

module eeprom_slave_model import eeprom_pkg::*; (
    input  wire  scl,
    input  wire  sda,
    input  wire  nack_inject,   // refuse control bytes while high
    output logic sda_pull
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [data_w-1:0] mem [0:(2**mem_addr_w)-1];

    int start_cnt;
    int restart_cnt;
    int stop_cnt;
    int fault_cnt;

    logic                  scl_q;
    logic                  sda_q;
    logic                  in_frame;
    logic                  tx;         // slave sending read data
    logic                  tx_next;
    logic                  ignore;     // control byte refused
    int                    bit_cnt;    // rising scl edges in the current byte
    int                    byte_num;
    logic [data_w-1:0]     shift;
    logic [data_w-1:0]     out_byte;
    logic [2:0]            block;
    logic [mem_addr_w-1:0] ptr;

    task automatic accept_byte;
        case (byte_num)
            0:
            begin
                if (shift[7:4] != device_code || nack_inject)
                    ignore = 1'b1;
                else
                begin
                    block   = shift[3:1];
                    ptr     = {shift[3:1], ptr[7:0]};
                    tx_next = shift[0];   // read direction
                end
            end
            1:
                ptr = {block, shift};
            default:
                mem[ptr] = shift;
        endcase
        byte_num++;
        sda_pull = !ignore;
    endtask

    task automatic frame_edge(input logic is_start);
        if (bit_cnt > 1)
        begin
            fault_cnt++;
            $display("%s condition in the middle of a byte at %0t",
                     is_start ? "start" : "stop", $time);
        end
        if (is_start && in_frame)
            restart_cnt++;
        else if (is_start)
            start_cnt++;
        else
            stop_cnt++;
        in_frame = is_start;
        bit_cnt  = 0;
        byte_num = 0;
        tx       = 1'b0;
        tx_next  = 1'b0;
        ignore   = 1'b0;
    endtask

    initial
    begin
        for (int i = 0; i < 2**mem_addr_w; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3);   // preset content follows the address
        sda_pull    = 1'b0;
        start_cnt   = 0;
        restart_cnt = 0;
        stop_cnt    = 0;
        fault_cnt   = 0;
        in_frame    = 1'b0;
        tx          = 1'b0;
        tx_next     = 1'b0;
        ignore      = 1'b0;
        bit_cnt     = 0;
        byte_num    = 0;
        shift       = '0;
        out_byte    = '0;
        block       = '0;
        ptr         = '0;
        scl_q       = scl;
        sda_q       = sda;
        forever
        begin
            @(scl or sda);
            if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b1 && sda === 1'b0)
                frame_edge(1'b1);
            else if (scl === 1'b1 && scl_q === 1'b1 && sda_q === 1'b0 && sda === 1'b1
                     && in_frame)
                frame_edge(1'b0);
            else if (scl_q === 1'b0 && scl === 1'b1 && in_frame)
            begin
                if (bit_cnt < 8)
                begin
                    shift = {shift[data_w-2:0], sda};
                    bit_cnt++;
                end
                else
                begin
                    bit_cnt = 0;   // ack clock
                    if (tx && sda)
                        tx = 1'b0;          // master nack ends the read
                    else if (tx)
                        ptr = ptr + 1'b1;
                end
            end
            else if (scl_q === 1'b1 && scl === 1'b0 && in_frame)
            begin
                sda_pull = 1'b0;
                if (bit_cnt == 8)
                begin
                    if (!tx && !ignore)
                        accept_byte();
                end
                else if (bit_cnt == 0)
                begin
                    if (tx_next)
                    begin
                        tx      = 1'b1;
                        tx_next = 1'b0;
                    end
                    if (tx)
                    begin
                        out_byte = mem[ptr];
                        sda_pull = !out_byte[data_w-1];
                    end
                end
                else if (tx)
                    sda_pull = !out_byte[data_w-1-bit_cnt];   // msb first
            end
            scl_q = scl;
            sda_q = sda;
        end
    end

endmodule

`default_nettype wire

//--- tests/eeprom_master_tb.sv
`default_nettype none

module eeprom_master_tb
    import eeprom_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_div     = 4;
    localparam int mem_size    = 2 ** mem_addr_w;
    localparam int txn_cycles  = 128 * clk_div;   // well above one random read
    localparam int watchdog_ns = 200 * 64 * clk_div * 8 * 2;

    logic                  CLK;
    logic                  RESET;
    logic                  wr;
    logic                  rd;
    logic [mem_addr_w-1:0] addr;
    logic [data_w-1:0]     wr_data;
    logic [data_w-1:0]     rd_data;
    logic                  busy;
    logic                  done;
    logic                  nack;
    logic                  scl;
    logic                  sda_oe;
    logic                  sda_pull;
    logic                  nack_inject;
    wire                   sda_line;

    logic [data_w-1:0] shadow [0:mem_size-1];
    int err_cnt;
    int check_cnt;
    int accepted;
    int done_cnt;
    int txn_cnt;
    int read_cnt;   // reads that reach the repeated start

    assign sda_line = !(sda_oe || sda_pull);   // open drain, low if anyone pulls

    eeprom_master_top #(
        .CLK_DIV (clk_div)
    ) u_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .busy    (busy),
        .done    (done),
        .nack    (nack),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda_line)
    );

    eeprom_slave_model u_mem (
        .scl         (scl),
        .sda         (sda_line),
        .nack_inject (nack_inject),
        .sda_pull    (sda_pull)
    );

    always #4 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_cnt++;
        if (expected !== actual)
        begin
            err_cnt++;
            $display("** Error: %s expected %0h actual %0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // one host request, checked against the shadow memory at done
    task automatic transfer(input string name, input logic is_wr,
                            input logic [mem_addr_w-1:0] a, input logic [data_w-1:0] d,
                            input logic inject);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        nack_inject = inject;
        addr        = a;
        wr_data     = d;
        wr          = is_wr;
        rd          = !is_wr || ($urandom_range(0, 3) == 0);   // both high, write wins
        if (!busy)
            accepted++;
        txn_cnt++;
        if (!is_wr && !inject)
            read_cnt++;
        @(negedge CLK);
        check_value({name, " busy"}, 1, busy);
        while (!done && cycles < txn_cycles)
        begin
            wr = 1'b0;
            rd = 1'b0;
            if (busy && $urandom_range(0, 15) == 0)
            begin
                if ($urandom_range(0, 1) == 1)
                    wr = 1'b1;
                else
                    rd = 1'b1;
            end
            @(negedge CLK);
            cycles++;
        end
        wr = 1'b0;
        rd = 1'b0;
        if (!done)
        begin
            err_cnt++;
            $display("no done pulse within %0d cycles for %s at address %0h",
                     txn_cycles, name, a);
        end
        else
        begin
            check_value({name, " nack"}, inject, nack);
            if (is_wr && !inject)
                shadow[a] = d;
            else if (!inject)
                check_value({name, " data"}, shadow[a], rd_data);
        end
        nack_inject = 1'b0;
    endtask

    // bus must rest with scl high and sda released whenever idle
    always @(negedge CLK)
    begin
        if (!RESET)
        begin
            if (done)
                done_cnt++;
            if (!busy)
            begin
                check_value("idle scl", 1, scl);
                check_value("idle sda_oe", 0, sda_oe);
            end
        end
    end

    initial
    begin
        #(watchdog_ns * 1ns);
        $display("watchdog expired after %0d ns", watchdog_ns);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        logic [mem_addr_w-1:0] a;
        logic [7:0]            lo;
        logic [data_w-1:0]     base;
        logic [data_w-1:0]     old;
        void'($urandom(62));
        CLK         = 1'b0;
        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wr_data     = '0;
        nack_inject = 1'b0;
        err_cnt     = 0;
        check_cnt   = 0;
        accepted    = 0;
        done_cnt    = 0;
        txn_cnt     = 0;
        read_cnt    = 0;
        for (int i = 0; i < mem_size; i++)
            shadow[i] = 8'(i) ^ 8'(i >> 3);   // same preset as the memory model
        repeat (10) @(posedge CLK);
        @(negedge CLK);
        RESET = 1'b0;

        // small pool of addresses so reads hit written bytes
        for (int i = 0; i < 120; i++)
        begin
            a = {3'($urandom), 8'($urandom_range(0, 15))};
            transfer("random", $urandom_range(0, 1) == 1, a, 8'($urandom), 1'b0);
        end

        // same low byte in all eight blocks
        lo   = 8'($urandom);
        base = 8'($urandom);
        for (int b = 0; b < 8; b++)
            transfer("block write", 1'b1, {3'(b), lo}, base ^ 8'(b * 33), 1'b0);
        for (int b = 0; b < 8; b++)
        begin
            transfer("block read", 1'b0, {3'(b), lo}, 8'h00, 1'b0);
            check_value("block value", base ^ 8'(b * 33), rd_data);
        end

        for (int k = 0; k < 4; k++)
        begin
            a   = 11'($urandom);
            old = 8'($urandom);
            transfer("nack setup", 1'b1, a, old, 1'b0);
            transfer("nack write", 1'b1, a, ~old, 1'b1);
            transfer("nack read", 1'b0, a, 8'h00, 1'b1);
            transfer("after nack", 1'b0, a, 8'h00, 1'b0);
            check_value("old value kept", old, rd_data);
        end

        @(negedge CLK);
        check_value("done count", accepted, done_cnt);
        check_value("starts", txn_cnt, u_mem.start_cnt);
        check_value("repeated starts", read_cnt, u_mem.restart_cnt);
        check_value("stops", txn_cnt, u_mem.stop_cnt);
        check_value("bus faults", 0, u_mem.fault_cnt);
        $display("checks %0d, errors %0d, bus faults %0d",
                 check_cnt, err_cnt, u_mem.fault_cnt);
        if (err_cnt == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
logic/eeprom_pkg.sv
logic/serial_bit_engine.sv
logic/eeprom_access_ctrl.sv
logic/eeprom_master_top.sv
tests/eeprom_slave_model.sv
tests/eeprom_master_tb.sv

//--- Makefile
# Verilator build and run of the EEPROM master testbench

VERILATOR ?= verilator
TOP       ?= eeprom_master_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
